//--- verilog.f
+incdir+include
hw/spritePkg.sv
hw/ps2Receiver.sv
hw/moveControl.sv
hw/spriteObject.sv
hw/spriteDemoTop.sv
verif/spriteDemo_checker.sv
verif/spriteDemoTb.sv

//--- run.sh
#!/bin/sh
# build and run the sprite demo testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module spriteDemoTb -o simDemo
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simDemo)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- sprite.hex
// one 9-bit colour word per line, row 0 col 0 first, 8 words per row
041
05E
07B
098
0B5
0D2
0EF
10C
129
146
163
180
19D
1BA
1D7
1F4
011
02E
04B
068
085
0A2
0BF
0DC
0F9
116
133
150
16D
18A
1A7
1C4
1E1
1FE
01B
038
055
072
08F
0AC
0C9
0E6
103
120
13D
15A
177
194
1B1
1CE
1EB
008
025
042
05F
07C
099
0B6
0D3
0F0
10D
12A
147
164

//--- include/spriteModel.svh
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

// true when the key moves the second sprite (d/f/r/c)
function automatic bit isSecondKey(input scancode_t code);
    return !code[4];
endfunction

// expected centre after one key, modulo the coordinate width
function automatic void movePosition(input scancode_t code, inout xCoord_t x,
                                     inout yCoord_t y);
    moveCodes_t codes;
    dirCode_t   dir;
    codes = code[4] ? objMap1 : objMap2;
    dir = code[4] ? code[1:0] : {code[3], code[1]};
    if (dir == codes.left) x = x - xCoord_t'(1);
    else if (dir == codes.right) x = x + xCoord_t'(1);
    else if (dir == codes.up) y = y - yCoord_t'(1);
    else if (dir == codes.down) y = y + yCoord_t'(1);
endfunction

// one 64-pixel pass with black as the erase colour
function automatic void queuePass(input xCoord_t x, input yCoord_t y, input bit erase,
                                  input color_t colors[objSide*objSide],
                                  ref pixelWrite_t q[$]);
    pixelWrite_t p;
    for (int r = 0; r < objSide; r++) begin
        for (int c = 0; c < objSide; c++) begin
            p.write = 1'b1;
            p.x = xCoord_t'(int'(x) - objSide / 2 + c);
            p.y = yCoord_t'(int'(y) - objSide / 2 + r);
            p.color = erase ? '0 : colors[r * objSide + c];
            q.push_back(p);
        end
    end
endfunction

// erase at old spot, move, redraw
function automatic void queueKeyStream(input scancode_t code, inout xCoord_t x,
                                       inout yCoord_t y,
                                       input color_t colors[objSide*objSide],
                                       ref pixelWrite_t q[$]);
    queuePass(x, y, 1'b1, colors, q);
    movePosition(code, x, y);
    queuePass(x, y, 1'b0, colors, q);
endfunction

`endif

//--- verif/spriteDemoTb.sv
`timescale 1ns/1ps

module spriteDemoTb import spritePkg::*; ();

    `include "spriteModel.svh"

    localparam int halfPs2 = 20;                    // system cycles per PS/2 half period
    localparam int keyCount = 2 + 1 + 12 + 1 + 175; // shows, key a, random, junk, wrap run
    localparam int cycleLimit = keyCount * 3000 + 2000;

    logic        CLOCK_50 = 1'b0;
    logic        reset;
    logic        showFirst;
    logic        showSecond;
    logic        ps2Clk;
    logic        ps2Dat;
    scancode_t   scancode;
    pixelWrite_t pixel;

    color_t      colors[objSide*objSide];           // same words the ROM loads
    pixelWrite_t expected[$];                       // writes still to come
    xCoord_t     x1;                                // model centres of both sprites
    yCoord_t     y1;
    xCoord_t     x2;
    yCoord_t     y2;
    int          cycleCount = 0;
    scancode_t   keys[8] = '{8'h1C, 8'h1B, 8'h1D, 8'h1A, 8'h23, 8'h2B, 8'h2D, 8'h21};

    spriteDemoTop DUT (.CLOCK_50, .reset, .showFirst, .showSecond, .ps2Clk, .ps2Dat,
                       .scancode, .pixel);

    always #2 CLOCK_50 = ~CLOCK_50;                 // 4 ns period

    task automatic tick();
        @(posedge CLOCK_50);
        #0.5;                                       // drive just after the edge
    endtask

    task automatic comparePixel(input pixelWrite_t got, input pixelWrite_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: pixel got x=%0d y=%0d color=%h, expected x=%0d y=%0d color=%h",
                     $time, got.x, got.y, got.color, exp.x, exp.y, exp.color);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic compareCode(input string name, input scancode_t got, input scancode_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // start, 8 data bits LSB first, odd parity, stop
    task automatic sendFrame(input scancode_t code);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        repeat (11) begin
            ps2Dat = bits[0];                       // data changes while clock high
            repeat (halfPs2) tick();
            ps2Clk = 1'b0;                          // receiver samples on this fall
            repeat (halfPs2) tick();
            ps2Clk = 1'b1;
            bits = bits >> 1;
        end
        repeat (2 * halfPs2) tick();                // idle gap between frames
    endtask

    task automatic sendKey(input scancode_t code);
        sendFrame(code);
        sendFrame(8'hF0);                           // release
        sendFrame(code);
    endtask

    // wait until every expected write has arrived
    task automatic waitDrained();
        while (expected.size() != 0) tick();
        repeat (4) tick();                          // hold, then control back to idle
    endtask

    task automatic pressKey(input scancode_t code);
        if (isSecondKey(code)) begin
            queueKeyStream(code, x2, y2, colors, expected);
        end else begin
            queueKeyStream(code, x1, y1, colors, expected);
        end
        sendKey(code);
        waitDrained();
        compareCode("scancode", scancode, code);
    endtask

    // every write beat must match the head of the model stream
    always @(posedge CLOCK_50) begin
        if (!reset && pixel.write) begin
            if (expected.size() == 0) begin
                $display("pixel write at %0t ns while no write was expected", $time);
                $display("Test failed");
                $fatal(1);
            end else begin
                comparePixel(pixel, expected.pop_front());
            end
        end
    end

    always @(posedge CLOCK_50) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $fatal(1);
        end
        if (DUT.protocolCheck.failCount != 0) begin
            $display("an assertion on the control strobes or pixel port failed");
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        logic [2:0] pick;
        scancode_t lastCode;
        void'($urandom(32'h93a43a5f));
        reset = 1'b1;
        showFirst = 1'b0;
        showSecond = 1'b0;
        ps2Clk = 1'b1;                              // PS/2 bus idles high
        ps2Dat = 1'b1;
        $readmemh("sprite.hex", colors);
        x1 = xCoord_t'(startX1);
        y1 = yCoord_t'(startY1);
        x2 = xCoord_t'(startX2);
        y2 = yCoord_t'(startY2);
        repeat (3) tick();
        reset = 1'b0;
        repeat (2) tick();                          // sprites pass through load

        // buttons draw each sprite in place
        queuePass(x1, y1, 1'b0, colors, expected);
        showFirst = 1'b1;
        repeat (3) tick();
        showFirst = 1'b0;
        waitDrained();
        queuePass(x2, y2, 1'b0, colors, expected);
        showSecond = 1'b1;
        repeat (3) tick();
        showSecond = 1'b0;
        waitDrained();

        pressKey(8'h1C);                            // key a moves the first sprite to 319

        repeat (12) begin
            pick = 3'($urandom_range(7, 0));
            pressKey(keys[pick]);
        end

        // mismatched first and third byte must not count as a press
        lastCode = keys[pick];                      // last random key stays latched
        sendFrame(8'h23);
        sendFrame(8'hF0);
        sendFrame(8'h2B);
        repeat (200) tick();
        compareCode("scancode", scancode, lastCode);

        // second sprite left until its centre wraps past 0
        while (x2 != xCoord_t'(1023)) pressKey(8'h23);

        $display("Test passed");
        $finish;
    end

endmodule

//--- verif/spriteDemo_checker.sv
`timescale 1ns/1ps

// control strobe and pixel port checks on the demo top level
module spriteDemo_checker import spritePkg::*; (
    input logic        CLOCK_50,
    input logic        reset,
    input logic        stepFirst,
    input logic        stepSecond,
    input logic        done,
    input pixelWrite_t pixel
);

    int failCount = 0;              // polled by the testbench

    // only one sprite moves per key
    stepsExclusive: assert property (@(posedge CLOCK_50) !(stepFirst && stepSecond))
        else begin
            $error("stepFirst and stepSecond high in the same cycle");
            failCount++;
        end

    writeQuietAfterReset: assert property (@(posedge CLOCK_50) reset |=> !pixel.write)
        else begin
            $error("pixel.write high right after reset");
            failCount++;
        end

    // control must be back in idle before it steps again
    noStepWhileDone: assert property (@(posedge CLOCK_50) disable iff (reset)
        !((stepFirst || stepSecond) && done))
        else begin
            $error("step pulse while done is high");
            failCount++;
        end

endmodule

bind spriteDemoTop spriteDemo_checker protocolCheck (
    .CLOCK_50, .reset, .stepFirst, .stepSecond, .done, .pixel
);

//--- hw/spriteDemoTop.sv
`timescale 1ns/1ps

// keyboard-driven two-sprite demo, pixel writes out on one port
module spriteDemoTop import spritePkg::*; (
    input  logic        CLOCK_50,
    input  logic        reset,
    input  logic        showFirst,      // push buttons, asynchronous
    input  logic        showSecond,
    input  logic        ps2Clk,
    input  logic        ps2Dat,
    output scancode_t   scancode,
    output pixelWrite_t pixel
);

    logic [1:0]  firstSync;         // two flops per key
    logic [1:0]  secondSync;
    logic        keyPress;
    scancode_t   frameCode;
    logic        stepFirst;
    logic        stepSecond;
    dirCode_t    dir;
    pixelWrite_t pixFirst;
    pixelWrite_t pixSecond;
    logic        doneFirst;
    logic        doneSecond;
    logic        done;
    logic        selSecond;         // mux select, set while sprite 2 owns the port

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            firstSync <= '0;
            secondSync <= '0;
        end else begin
            firstSync <= {firstSync[0], showFirst};
            secondSync <= {secondSync[0], showSecond};
        end
    end

    ps2Receiver receiver (.CLOCK_50, .reset, .ps2Clk, .ps2Dat, .keyPress, .frameCode);

    moveControl control (
        .CLOCK_50, .reset, .keyPress, .frameCode, .done,
        .scancode, .stepFirst, .stepSecond, .dir
    );

    spriteObject #(.startX(xCoord_t'(startX1)), .startY(yCoord_t'(startY1)), .codes(objMap1))
        firstSprite (
            .CLOCK_50, .reset, .go(firstSync[1]), .step(stepFirst), .dir,
            .pixel(pixFirst), .done(doneFirst)
        );

    spriteObject #(.startX(xCoord_t'(startX2)), .startY(yCoord_t'(startY2)), .codes(objMap2))
        secondSprite (
            .CLOCK_50, .reset, .go(secondSync[1]), .step(stepSecond), .dir,
            .pixel(pixSecond), .done(doneSecond)
        );

    assign done = doneFirst | doneSecond;

    always_ff @(posedge CLOCK_50) begin
        if (reset || firstSync[1]) begin
            selSecond <= 1'b0;
        end else if (secondSync[1]) begin
            selSecond <= 1'b1;
        end else if (stepFirst || stepSecond) begin
            selSecond <= stepSecond;    // follow whichever sprite is moving
        end
    end

    assign pixel = selSecond ? pixSecond : pixFirst;

endmodule

//--- hw/spriteObject.sv
`timescale 1ns/1ps

// one movable sprite: erase at old spot, move one pixel, redraw from colour ROM
module spriteObject import spritePkg::*; #(
    parameter xCoord_t    startX = xCoord_t'(startX1),   // sprite centre after load
    parameter yCoord_t    startY = yCoord_t'(startY1),
    parameter moveCodes_t codes  = objMap1               // which dir codes mean what
) (
    input  logic        CLOCK_50,
    input  logic        reset,
    input  logic        go,         // synchronized key, draw in place
    input  logic        step,       // one-cycle move request
    input  dirCode_t    dir,
    output pixelWrite_t pixel,
    output logic        done
);

    drawState_t state, nextState;
    xCoord_t posX;                  // centre position
    yCoord_t posY;
    logic [objLog-1:0] col;         // pixel inside the sprite
    logic [objLog-1:0] row;
    logic writeEn;                  // decoded from state
    logic erase;
    logic lastCol;
    logic lastRow;
    color_t spriteMem [objSide*objSide];
    color_t memData;
    logic pixWrite;                 // pixel stage, aligned with memData
    logic pixErase;
    xCoord_t pixX;
    yCoord_t pixY;

    initial $readmemh(spriteFile, spriteMem);

    assign lastCol = &col;          // side is a power of two
    assign lastRow = &row;

    always_comb begin
        nextState = state;
        unique case (state)
            stLoad:      nextState = stReady;
            stReady: begin
                if (go) nextState = stDrawRow;          // show only, no erase
                else if (step) nextState = stEraseRow;
            end
            stEraseRow:  if (lastCol) nextState = stEraseNext;
            stEraseNext: nextState = lastRow ? stMove : stEraseRow;
            stMove:      nextState = stDrawRow;
            stDrawRow:   if (lastCol) nextState = stDrawNext;
            stDrawNext:  nextState = lastRow ? stHold : stDrawRow;
            stHold:      if (!go) nextState = stReady;  // stays while key held
            default:     nextState = stLoad;
        endcase
    end

    assign writeEn = (state == stEraseRow) || (state == stDrawRow);
    assign erase = (state == stEraseRow);
    assign done = (state == stHold);

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= stLoad;
            col <= '0;
            row <= '0;
        end else begin
            state <= nextState;
            case (state)
                stReady: begin
                    col <= '0;
                    row <= '0;
                end
                stEraseRow, stDrawRow: col <= col + objLog'(1);  // wraps to 0 after last
                stEraseNext, stDrawNext: row <= row + objLog'(1);
                default: ;
            endcase
        end
    end

    // centre position, wraps modulo the coordinate width
    always_ff @(posedge CLOCK_50) begin
        if (state == stLoad) begin
            posX <= startX;
            posY <= startY;
        end else if (state == stMove) begin
            if (dir == codes.left) posX <= posX - xCoord_t'(1);
            else if (dir == codes.right) posX <= posX + xCoord_t'(1);
            else if (dir == codes.up) posY <= posY - yCoord_t'(1);     // y grows downward
            else if (dir == codes.down) posY <= posY + yCoord_t'(1);
        end
    end

    // ROM read and coordinate register share one cycle of latency
    always_ff @(posedge CLOCK_50) begin
        memData <= spriteMem[{row, col}];
        pixErase <= erase;
        pixX <= posX - xCoord_t'(objSide / 2) + xCoord_t'(col);   // centred on posX
        pixY <= posY - yCoord_t'(objSide / 2) + yCoord_t'(row);
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            pixWrite <= 1'b0;
        end else begin
            pixWrite <= writeEn;
        end
    end

    // erase paints black background
    assign pixel = '{write: pixWrite, x: pixX, y: pixY, color: pixErase ? '0 : memData};

endmodule

//--- hw/moveControl.sv
`timescale 1ns/1ps

// latches a key, sends one step to the chosen sprite and waits for its redraw
module moveControl import spritePkg::*; (
    input  logic      CLOCK_50,
    input  logic      reset,
    input  logic      keyPress,
    input  scancode_t frameCode,
    input  logic      done,         // either sprite finished its draw
    output scancode_t scancode,     // latched key
    output logic      stepFirst,
    output logic      stepSecond,
    output dirCode_t  dir
);

    ctrlState_t state, nextState;
    logic       objFirst;           // bit 4 set for a/s/w/z

    always_comb begin
        nextState = state;
        unique case (state)
            stIdle:  if (keyPress) nextState = stLatch;
            stLatch: nextState = stStep;
            stStep:  nextState = stWait;
            stWait:  if (done) nextState = stIdle;     // presses in here are dropped
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            scancode <= '0;
        end else if (state == stLatch) begin
            scancode <= frameCode;  // frame stays put until the next PS/2 edge
        end
    end

    assign objFirst = scancode[4];
    assign stepFirst = (state == stStep) && objFirst;
    assign stepSecond = (state == stStep) && !objFirst;

    // a/s/w/z differ in bits 1..0, d/f/r/c in bits 3 and 1
    assign dir = objFirst ? scancode[1:0] : {scancode[3], scancode[1]};

endmodule

//--- hw/ps2Receiver.sv
`timescale 1ns/1ps

// PS/2 keyboard receiver, looks for make / F0 / make over three frames
module ps2Receiver import spritePkg::*; (
    input  logic      CLOCK_50,
    input  logic      reset,
    input  logic      ps2Clk,       // asynchronous, idles high
    input  logic      ps2Dat,
    output logic      keyPress,     // one cycle per complete press
    output scancode_t frameCode     // data byte of newest frame
);

    logic [1:0] clkSync;            // two-flop synchronizers
    logic [1:0] datSync;
    logic       prevClk;            // synchronized clock one cycle back
    logic       fallEdge;
    logic [32:0] frame;             // three 11-bit frames, newest at the top
    logic [3:0] bitCount;           // bits of the current frame

    // bring the keyboard lines into the system clock domain
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            clkSync <= 2'b11;       // bus idle level
            datSync <= 2'b11;
            prevClk <= 1'b1;
        end else begin
            clkSync <= {clkSync[0], ps2Clk};
            datSync <= {datSync[0], ps2Dat};
            prevClk <= clkSync[1];
        end
    end

    assign fallEdge = prevClk && !clkSync[1];   // keyboard drives data on rising, sample on fall

    // shift in LSB first: start, d0..d7, parity, stop
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            frame <= '0;
        end else if (fallEdge) begin
            frame <= {datSync[1], frame[32:1]};
        end
    end

    // count wraps after the stop bit
    always_ff @(posedge CLOCK_50) begin
        if (reset || bitCount == 4'd11) begin
            bitCount <= '0;
        end else if (fallEdge) begin
            bitCount <= bitCount + 4'd1;
        end
    end

    assign frameCode = frame[30:23];    // data bits of the last frame
    // key repeat gives make/make/make, so only a matching first and third byte counts
    assign keyPress = (bitCount == 4'd11) && (frame[30:23] == frame[8:1]);

endmodule

//--- hw/spritePkg.sv
package spritePkg;

    // screen fixed at 640x480, 9-bit colour
    localparam int xWidth = 10;
    localparam int yWidth = 9;
    localparam int colorWidth = 9;

    localparam int objLog = 3;              // sprite is 2^objLog on a side
    localparam int objSide = 1 << objLog;

    localparam int startX1 = 320;           // first sprite starts mid-screen
    localparam int startY1 = 240;
    localparam int startX2 = 160;
    localparam int startY2 = 150;

    localparam string spriteFile = "sprite.hex";    // 64 colour words, row by row

    typedef logic [xWidth-1:0] xCoord_t;
    typedef logic [yWidth-1:0] yCoord_t;
    typedef logic [colorWidth-1:0] color_t;
    typedef logic [7:0] scancode_t;         // PS/2 set 2 make code
    typedef logic [1:0] dirCode_t;

    // one pixel write toward the frame buffer
    typedef struct packed {
        logic    write;
        xCoord_t x;
        yCoord_t y;
        color_t  color;
    } pixelWrite_t;

    // direction codes one sprite reacts to
    typedef struct packed {
        dirCode_t left;
        dirCode_t right;
        dirCode_t up;
        dirCode_t down;
    } moveCodes_t;

    localparam moveCodes_t objMap1 = '{left: 2'b00, right: 2'b11, up: 2'b01, down: 2'b10};
    localparam moveCodes_t objMap2 = '{left: 2'b01, right: 2'b11, up: 2'b10, down: 2'b00};

    typedef enum logic [1:0] {stIdle, stLatch, stStep, stWait} ctrlState_t;

    typedef enum logic [2:0] {
        stLoad, stReady, stEraseRow, stEraseNext, stMove, stDrawRow, stDrawNext, stHold
    } drawState_t;

endpackage
